// File: sd_spi_defs.svh
// Build-time constants for the SD card SPI transmit path
// Include this in any file that needs queue sizes, CRC polynomials or the block format
`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

// Queue depths, equal to the host's starting credits
`define SD_CMD_FIFO_DEPTH  4
`define SD_DATA_FIFO_DEPTH 16

// Data block format
`define SD_BLOCK_BYTES 512
`define SD_DATA_TOKEN  8'hFE

// Generator polynomials without the top term
`define SD_CRC7_POLY  7'h09
`define SD_CRC16_POLY 16'h1021

`endif

// File: sd_spi_pkg.sv
// Types shared by the SD card SPI transmit RTL and its testbench
// Import with a wildcard where the request or byte types are needed
package sd_spi_pkg;

  // One queued host request, either a command or a data block
  typedef struct packed {
    logic        is_data;
    logic [5:0]  cmd_index;
    logic [31:0] argument;
  } sd_cmd_t;

  // One byte of a data block
  typedef logic [7:0] sd_byte_t;

endpackage

// File: sd_credit_fifo.sv
// Circular FIFO with credit return toward the host
// The host never pushes without a credit, so there is no full or ready output
`timescale 1ns/1ps

module sd_credit_fifo
  import sd_spi_pkg::*;
#(
  parameter type payload_t = sd_cmd_t,
  parameter int  depth     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     head_valid,
  output payload_t head,
  input  logic     pop,
  output logic     credit
);

  localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;
  logic               pop_ok;

  assign pop_ok     = pop && head_valid;
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // Storage
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back for each slot freed
      credit <= pop_ok;
    end
  end

endmodule

// File: sd_crc_lfsr.sv
// Serial CRC generator, one bit per advance
// Accumulates message bits, then shifts its remainder out from the top bit
`timescale 1ns/1ps

module sd_crc_lfsr #(
  parameter int               width = 7,
  parameter logic [width-1:0] poly  = 7'h09
) (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic advance,
  input  logic bit_in,
  input  logic unload,
  output logic crc_bit
);

  logic [width-1:0] remainder;
  logic             feedback;

  assign feedback = bit_in ^ remainder[width-1];
  assign crc_bit  = remainder[width-1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      remainder <= '0;
    end else if (clear) begin
      remainder <= '0;
    end else if (advance) begin
      if (unload) begin
        // Zero fill while the remainder goes out
        remainder <= {remainder[width-2:0], 1'b0};
      end else begin
        remainder <= {remainder[width-2:0], 1'b0} ^ (feedback ? poly : '0);
      end
    end
  end

endmodule

// File: sd_frame_sender.sv
// Builds SPI command and data frames and serializes them one bit per clock
// Drives MOSI, chip select and a strobe marking the cycles that carry a frame bit
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_frame_sender
  import sd_spi_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     cmd_head_valid,
  input  sd_cmd_t  cmd_head,
  output logic     cmd_pop,
  input  logic     byte_head_valid,
  input  sd_byte_t byte_head,
  output logic     byte_pop,
  output logic     crc7_clear,
  output logic     crc7_advance,
  output logic     crc7_unload,
  input  logic     crc7_bit,
  output logic     crc16_clear,
  output logic     crc16_advance,
  output logic     crc16_unload,
  input  logic     crc16_bit,
  output logic     crc_bit_in,
  output logic     mosi,
  output logic     chip_select_n,
  output logic     bit_strobe
);

  localparam int byte_cnt_w = $clog2(`SD_BLOCK_BYTES);

  typedef enum logic [2:0] {
    st_idle,
    st_command,
    st_token,
    st_payload,
    st_crc,
    st_gap
  } state_t;

  state_t                state, state_next;
  logic [39:0]           cmd_shift;
  logic [7:0]            byte_shift;
  logic [5:0]            bit_cnt, bit_cnt_next;
  logic [byte_cnt_w-1:0] byte_cnt, byte_cnt_next;
  logic                  byte_ready, byte_ready_next;
  logic                  mosi_next;
  logic                  cs_n_next;
  logic                  strobe_next;
  logic                  load_cmd;
  logic                  shift_cmd;
  logic                  load_token;
  logic                  load_byte;
  logic                  shift_byte;

  // The bit being registered onto MOSI is also the CRC input
  assign crc_bit_in = mosi_next;

  always_comb begin
    state_next      = state;
    bit_cnt_next    = bit_cnt;
    byte_cnt_next   = byte_cnt;
    byte_ready_next = byte_ready;
    mosi_next       = mosi;
    cs_n_next       = chip_select_n;
    strobe_next     = 1'b0;
    cmd_pop         = 1'b0;
    byte_pop        = 1'b0;
    crc7_clear      = 1'b0;
    crc7_advance    = 1'b0;
    crc7_unload     = 1'b0;
    crc16_clear     = 1'b0;
    crc16_advance   = 1'b0;
    crc16_unload    = 1'b0;
    load_cmd        = 1'b0;
    shift_cmd       = 1'b0;
    load_token      = 1'b0;
    load_byte       = 1'b0;
    shift_byte      = 1'b0;

    case (state)
      st_idle: begin
        mosi_next = 1'b1;
        cs_n_next = 1'b1;
        if (cmd_head_valid) begin
          cmd_pop = 1'b1;
          if (cmd_head.is_data) begin
            load_token      = 1'b1;
            crc16_clear     = 1'b1;
            bit_cnt_next    = 6'd7;
            byte_cnt_next   = byte_cnt_w'(`SD_BLOCK_BYTES - 1);
            byte_ready_next = 1'b0;
            state_next      = st_token;
          end else begin
            load_cmd     = 1'b1;
            crc7_clear   = 1'b1;
            bit_cnt_next = 6'd47;
            state_next   = st_command;
          end
        end
      end

      st_command: begin
        cs_n_next    = 1'b0;
        strobe_next  = 1'b1;
        bit_cnt_next = bit_cnt - 1'b1;
        if (bit_cnt >= 6'd8) begin
          // Start, transmission, index and argument bits
          mosi_next    = cmd_shift[39];
          shift_cmd    = 1'b1;
          crc7_advance = 1'b1;
        end else if (bit_cnt != 6'd0) begin
          mosi_next    = crc7_bit;
          crc7_advance = 1'b1;
          crc7_unload  = 1'b1;
        end else begin
          // End bit
          mosi_next  = 1'b1;
          state_next = st_gap;
        end
      end

      st_token: begin
        cs_n_next    = 1'b0;
        strobe_next  = 1'b1;
        mosi_next    = byte_shift[7];
        shift_byte   = 1'b1;
        bit_cnt_next = bit_cnt - 1'b1;
        if (bit_cnt == 6'd0) begin
          state_next      = st_payload;
          byte_ready_next = byte_head_valid;
          if (byte_head_valid) begin
            byte_pop     = 1'b1;
            load_byte    = 1'b1;
            bit_cnt_next = 6'd7;
          end
        end
      end

      st_payload: begin
        cs_n_next = 1'b0;
        if (!byte_ready) begin
          // Starved, so MOSI holds and the strobe stays low
          if (byte_head_valid) begin
            byte_pop        = 1'b1;
            load_byte       = 1'b1;
            byte_ready_next = 1'b1;
            bit_cnt_next    = 6'd7;
          end
        end else begin
          strobe_next   = 1'b1;
          mosi_next     = byte_shift[7];
          shift_byte    = 1'b1;
          crc16_advance = 1'b1;
          bit_cnt_next  = bit_cnt - 1'b1;
          if (bit_cnt == 6'd0) begin
            if (byte_cnt == '0) begin
              bit_cnt_next    = 6'd15;
              byte_ready_next = 1'b0;
              state_next      = st_crc;
            end else begin
              byte_cnt_next   = byte_cnt - 1'b1;
              byte_ready_next = byte_head_valid;
              if (byte_head_valid) begin
                byte_pop     = 1'b1;
                load_byte    = 1'b1;
                bit_cnt_next = 6'd7;
              end
            end
          end
        end
      end

      st_crc: begin
        cs_n_next     = 1'b0;
        strobe_next   = 1'b1;
        mosi_next     = crc16_bit;
        crc16_advance = 1'b1;
        crc16_unload  = 1'b1;
        bit_cnt_next  = bit_cnt - 1'b1;
        if (bit_cnt == 6'd0) begin
          state_next = st_gap;
        end
      end

      st_gap: begin
        // Chip select goes high between frames
        mosi_next  = 1'b1;
        cs_n_next  = 1'b1;
        state_next = st_idle;
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state         <= st_idle;
      bit_cnt       <= '0;
      byte_cnt      <= '0;
      byte_ready    <= 1'b0;
      mosi          <= 1'b1;
      chip_select_n <= 1'b1;
      bit_strobe    <= 1'b0;
    end else begin
      state         <= state_next;
      bit_cnt       <= bit_cnt_next;
      byte_cnt      <= byte_cnt_next;
      byte_ready    <= byte_ready_next;
      mosi          <= mosi_next;
      chip_select_n <= cs_n_next;
      bit_strobe    <= strobe_next;
    end
  end

  // Frame shift registers
  always_ff @(posedge clock) begin
    if (load_cmd) begin
      cmd_shift <= {1'b0, 1'b1, cmd_head.cmd_index, cmd_head.argument};
    end else if (shift_cmd) begin
      cmd_shift <= {cmd_shift[38:0], 1'b0};
    end

    if (load_token) begin
      byte_shift <= `SD_DATA_TOKEN;
    end else if (load_byte) begin
      byte_shift <= byte_head;
    end else if (shift_byte) begin
      byte_shift <= {byte_shift[6:0], 1'b0};
    end
  end

endmodule

// File: sd_spi_top.sv
// Top level of the SD card SPI transmit path
// Host requests and data bytes enter two credit queues and leave serialized on MOSI
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_spi_top
  import sd_spi_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        cmd_valid,
  input  logic        cmd_is_data,
  input  logic [5:0]  cmd_index,
  input  logic [31:0] cmd_argument,
  output logic        cmd_credit,
  input  logic        data_valid,
  input  logic [7:0]  data_byte,
  output logic        data_credit,
  output logic        mosi,
  output logic        chip_select_n,
  output logic        bit_strobe
);

  sd_cmd_t  cmd_push_data;
  sd_cmd_t  cmd_head;
  logic     cmd_head_valid;
  logic     cmd_pop;
  sd_byte_t byte_head;
  logic     byte_head_valid;
  logic     byte_pop;
  logic     crc7_clear, crc7_advance, crc7_unload, crc7_bit;
  logic     crc16_clear, crc16_advance, crc16_unload, crc16_bit;
  logic     crc_bit_in;

  assign cmd_push_data.is_data   = cmd_is_data;
  assign cmd_push_data.cmd_index = cmd_index;
  assign cmd_push_data.argument  = cmd_argument;

  sd_credit_fifo #(
    .payload_t (sd_cmd_t),
    .depth     (`SD_CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (cmd_valid),
    .push_data  (cmd_push_data),
    .head_valid (cmd_head_valid),
    .head       (cmd_head),
    .pop        (cmd_pop),
    .credit     (cmd_credit)
  );

  sd_credit_fifo #(
    .payload_t (sd_byte_t),
    .depth     (`SD_DATA_FIFO_DEPTH)
  ) u_data_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (data_valid),
    .push_data  (data_byte),
    .head_valid (byte_head_valid),
    .head       (byte_head),
    .pop        (byte_pop),
    .credit     (data_credit)
  );

  // CRC7 covers the first 40 command bits
  sd_crc_lfsr #(
    .width (7),
    .poly  (`SD_CRC7_POLY)
  ) u_crc7 (
    .clock   (clock),
    .reset   (reset),
    .clear   (crc7_clear),
    .advance (crc7_advance),
    .bit_in  (crc_bit_in),
    .unload  (crc7_unload),
    .crc_bit (crc7_bit)
  );

  // CRC16 covers the data bytes, not the token
  sd_crc_lfsr #(
    .width (16),
    .poly  (`SD_CRC16_POLY)
  ) u_crc16 (
    .clock   (clock),
    .reset   (reset),
    .clear   (crc16_clear),
    .advance (crc16_advance),
    .bit_in  (crc_bit_in),
    .unload  (crc16_unload),
    .crc_bit (crc16_bit)
  );

  sd_frame_sender u_sender (
    .clock           (clock),
    .reset           (reset),
    .cmd_head_valid  (cmd_head_valid),
    .cmd_head        (cmd_head),
    .cmd_pop         (cmd_pop),
    .byte_head_valid (byte_head_valid),
    .byte_head       (byte_head),
    .byte_pop        (byte_pop),
    .crc7_clear      (crc7_clear),
    .crc7_advance    (crc7_advance),
    .crc7_unload     (crc7_unload),
    .crc7_bit        (crc7_bit),
    .crc16_clear     (crc16_clear),
    .crc16_advance   (crc16_advance),
    .crc16_unload    (crc16_unload),
    .crc16_bit       (crc16_bit),
    .crc_bit_in      (crc_bit_in),
    .mosi            (mosi),
    .chip_select_n   (chip_select_n),
    .bit_strobe      (bit_strobe)
  );

endmodule

// File: tb_sd_spi.sv
// Testbench for the SD card SPI transmit path
// Random host traffic under credit rules, a MOSI frame parser and a reference CRC model
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module tb_sd_spi
  import sd_spi_pkg::*;
();

  localparam int num_requests = 40;
  localparam int wait_limit   = 10000;
  localparam int drain_limit  = 40000;

  logic        clock;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_is_data;
  logic [5:0]  cmd_index;
  logic [31:0] cmd_argument;
  logic        cmd_credit;
  logic        data_valid;
  logic [7:0]  data_byte;
  logic        data_credit;
  logic        mosi;
  logic        chip_select_n;
  logic        bit_strobe;

  integer   seed = 32'hf5b73f32;
  int       cmd_credits, data_credits;
  int       cmd_pushes, data_pushes, cmd_returns, data_returns;
  int       bytes_owed, stall_left;
  int       value_errors, timeouts;
  int       frames_seen, starve_cycles, gap_cycles;
  sd_cmd_t  exp_req[$];
  sd_byte_t exp_bytes[$];
  logic     rx_bits[$];
  logic     in_frame;
  logic     last_bit;
  sd_cmd_t  cur_req;

  sd_spi_top u_dut (
    .clock         (clock),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_is_data   (cmd_is_data),
    .cmd_index     (cmd_index),
    .cmd_argument  (cmd_argument),
    .cmd_credit    (cmd_credit),
    .data_valid    (data_valid),
    .data_byte     (data_byte),
    .data_credit   (data_credit),
    .mosi          (mosi),
    .chip_select_n (chip_select_n),
    .bit_strobe    (bit_strobe)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic report_error(input string msg);
    $display("error @%0t: %s", $time, msg);
    value_errors++;
  endtask

  // Reference CRC steps go MSB first with the message bit XOR the top remainder bit
  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic b);
    logic fb;
    fb = b ^ crc[6];
    crc7_step = {crc[5:0], 1'b0} ^ (fb ? `SD_CRC7_POLY : 7'h00);
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic b);
    logic fb;
    fb = b ^ crc[15];
    crc16_step = {crc[14:0], 1'b0} ^ (fb ? `SD_CRC16_POLY : 16'h0000);
  endfunction

  // CMD0 gives 7'h4A and a block of 512 bytes 8'hFF gives 16'h7FA1
  task automatic check_crc_model();
    logic [39:0] cmd0;
    logic [6:0]  c7;
    logic [15:0] c16;
    int          i;
    cmd0 = 40'h40_0000_0000;
    c7   = '0;
    c16  = '0;
    for (i = 39; i >= 0; i--) c7 = crc7_step(c7, cmd0[i]);
    for (i = 0; i < 4096; i++) c16 = crc16_step(c16, 1'b1);
    assert (c7 == 7'h4A) else report_error($sformatf("CRC7 model gives %h for CMD0", c7));
    assert (c16 == 16'h7FA1) else report_error($sformatf("CRC16 model gives %h", c16));
  endtask

  // Step just past the clock edge and collect credit pulses
  task automatic host_cycle();
    @(posedge clock);
    #1;
    if (cmd_credit) begin
      cmd_credits++;
      cmd_returns++;
    end
    if (data_credit) begin
      data_credits++;
      data_returns++;
    end
    assert (cmd_credits <= `SD_CMD_FIFO_DEPTH && data_credits <= `SD_DATA_FIFO_DEPTH)
      else report_error("credit counter above queue depth");
  endtask

  task automatic drive_traffic();
    sd_cmd_t req;
    int      reqs_left;
    int      idle_cycles;
    logic    progress;
    reqs_left   = num_requests;
    idle_cycles = 0;
    while (reqs_left > 0 || bytes_owed > 0) begin
      host_cycle();
      cmd_valid  = 1'b0;
      data_valid = 1'b0;
      progress   = 1'b0;
      if (reqs_left > 0 && cmd_credits > 0 && ($random(seed) & 3) != 0) begin
        req.is_data   = (($random(seed) & 3) == 0);
        req.cmd_index = 6'($random(seed));
        req.argument  = $random(seed);
        cmd_valid     = 1'b1;
        cmd_is_data   = req.is_data;
        cmd_index     = req.cmd_index;
        cmd_argument  = req.argument;
        exp_req.push_back(req);
        cmd_credits--;
        cmd_pushes++;
        reqs_left--;
        if (req.is_data) bytes_owed += `SD_BLOCK_BYTES;
        progress = 1'b1;
      end
      if (stall_left > 0) begin
        stall_left--;
      end else if (bytes_owed > 0 && data_credits > 0) begin
        // Long enough withholds drain the byte queue mid block
        if (($random(seed) & 63) == 0) begin
          stall_left = 160 + ($random(seed) & 127);
        end else if (($random(seed) & 3) != 0) begin
          data_valid = 1'b1;
          data_byte  = 8'($random(seed));
          exp_bytes.push_back(data_byte);
          data_credits--;
          data_pushes++;
          bytes_owed--;
          progress = 1'b1;
        end
      end
      idle_cycles = progress ? 0 : idle_cycles + 1;
      if (idle_cycles > wait_limit) begin
        $display("timeout: host could not push for %0d cycles, credits stopped coming back",
                 idle_cycles);
        timeouts++;
        break;
      end
    end
    host_cycle();
    cmd_valid  = 1'b0;
    data_valid = 1'b0;
  endtask

  // Every pop and its credit lie before the end of the last frame
  task automatic drain_run();
    int waited;
    waited = 0;
    while (exp_req.size() != 0 || in_frame) begin
      host_cycle();
      waited++;
      if (waited > drain_limit) begin
        $display("timeout: outstanding frames did not finish after %0d cycles", waited);
        timeouts++;
        break;
      end
    end
  endtask

  task automatic check_frame();
    logic        exp_bits[$];
    logic [39:0] head;
    logic [6:0]  c7;
    logic [15:0] c16;
    sd_byte_t    b;
    int          i;
    int          k;
    int          bad;
    int          first_bad;
    frames_seen++;
    if (!cur_req.is_data) begin
      head = {2'b01, cur_req.cmd_index, cur_req.argument};
      c7   = '0;
      for (i = 39; i >= 0; i--) begin
        exp_bits.push_back(head[i]);
        c7 = crc7_step(c7, head[i]);
      end
      for (i = 6; i >= 0; i--) exp_bits.push_back(c7[i]);
      exp_bits.push_back(1'b1);
      assert (gap_cycles == 0)
        else report_error($sformatf("command frame %0d has %0d gaps", frames_seen, gap_cycles));
    end else begin
      b = `SD_DATA_TOKEN;
      for (i = 7; i >= 0; i--) exp_bits.push_back(b[i]);
      c16 = '0;
      assert (exp_bytes.size() >= `SD_BLOCK_BYTES)
        else report_error("data frame sent before its bytes were pushed");
      for (k = 0; k < `SD_BLOCK_BYTES && exp_bytes.size() > 0; k++) begin
        b = exp_bytes.pop_front();
        for (i = 7; i >= 0; i--) begin
          exp_bits.push_back(b[i]);
          c16 = crc16_step(c16, b[i]);
        end
      end
      for (i = 15; i >= 0; i--) exp_bits.push_back(c16[i]);
      starve_cycles += gap_cycles;
    end
    assert (rx_bits.size() == exp_bits.size())
      else report_error($sformatf("frame %0d has %0d strobed bits, expected %0d",
                                  frames_seen, rx_bits.size(), exp_bits.size()));
    bad       = 0;
    first_bad = -1;
    for (i = 0; i < rx_bits.size() && i < exp_bits.size(); i++) begin
      if (rx_bits[i] !== exp_bits[i]) begin
        if (bad == 0) first_bad = i;
        bad++;
      end
    end
    assert (bad == 0)
      else report_error($sformatf("frame %0d has %0d wrong bits, first at bit %0d",
                                  frames_seen, bad, first_bad));
  endtask

  // Parser samples at the falling edge, away from output updates
  always @(negedge clock) begin
    if (!reset) begin
      assert (!(bit_strobe && chip_select_n)) else report_error("strobe with chip select high");
      if (!in_frame && !chip_select_n) begin
        assert (exp_req.size() > 0) else report_error("frame with no request outstanding");
        if (exp_req.size() > 0) cur_req = exp_req.pop_front();
        in_frame   = 1'b1;
        gap_cycles = 0;
        rx_bits.delete();
      end
      if (in_frame) begin
        if (chip_select_n) begin
          check_frame();
          in_frame = 1'b0;
        end else if (bit_strobe) begin
          rx_bits.push_back(mosi);
          last_bit = mosi;
        end else begin
          gap_cycles++;
          assert (rx_bits.size() == 0 || mosi === last_bit)
            else report_error("mosi changed while the frame was stalled");
        end
      end
    end
  end

  initial begin
    reset         = 1'b1;
    cmd_valid     = 1'b0;
    cmd_is_data   = 1'b0;
    cmd_index     = '0;
    cmd_argument  = '0;
    data_valid    = 1'b0;
    data_byte     = '0;
    in_frame      = 1'b0;
    last_bit      = 1'b1;
    cmd_credits   = `SD_CMD_FIFO_DEPTH;
    data_credits  = `SD_DATA_FIFO_DEPTH;
    check_crc_model();
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;

    // Quiet outputs and no credits while nothing is pushed
    repeat (8) begin
      host_cycle();
      assert (chip_select_n === 1'b1 && mosi === 1'b1 && bit_strobe === 1'b0)
        else report_error("outputs not idle after reset");
      assert (cmd_credit === 1'b0 && data_credit === 1'b0)
        else report_error("credit pulse with nothing pushed");
    end

    drive_traffic();
    if (timeouts == 0) drain_run();

    assert (frames_seen == num_requests)
      else report_error($sformatf("%0d frames seen, expected %0d", frames_seen, num_requests));
    assert (cmd_returns == cmd_pushes && data_returns == data_pushes)
      else report_error("credits returned differ from entries pushed");
    assert (cmd_credits == `SD_CMD_FIFO_DEPTH && data_credits == `SD_DATA_FIFO_DEPTH)
      else report_error("credit counters not back at queue depths");
    assert (exp_bytes.size() == 0) else report_error("pushed bytes left unsent");
    assert (starve_cycles > 0) else report_error("no byte starvation inside a data block");

    $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+.
sd_spi_pkg.sv
sd_credit_fifo.sv
sd_crc_lfsr.sv
sd_frame_sender.sv
sd_spi_top.sv
tb_sd_spi.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_sd_spi
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST) *.sv *.svh
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
